/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= csr_block_top.f
TB_TOP    ?= csr_block_tb
RTL_TOP   ?= csr_block_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* csr_block_top.f */
verilog/csr_pkg.sv
verilog/csr_bus_adapter.sv
verilog/csr_adapter_common.sv
verilog/csr_rw_register.sv
verilog/csr_status_register.sv
verilog/csr_block_top.sv
sim/csr_block_sva.sv
sim/csr_block_tb.sv

/* sim/csr_block_sva.sv */
`timescale 1ns/10ps

module csr_block_sva #(
  parameter int BUS_WIDTH = 32
)(
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_request_ready,
  input logic                 i_response_valid,
  input logic                 i_response_ready,
  input logic [BUS_WIDTH-1:0] i_read_data,
  input logic                 i_error
);

  ////////////////////////////////////////
  // host handshake
  ////////////////////////////////////////

  a_ready_blocked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_response_valid |-> !i_request_ready)
    else $error("request ready high while a response is pending");

  a_response_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_response_valid && !i_response_ready |=>
      i_response_valid && $stable(i_read_data) && $stable(i_error))
    else $error("response changed before acknowledge");

  a_valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(i_response_valid))
    else $error("response valid is unknown");

endmodule

bind csr_bus_adapter csr_block_sva #(.BUS_WIDTH(BUS_WIDTH)) sva_i (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_request_ready  (o_request_ready),
  .i_response_valid (o_response_valid),
  .i_response_ready (i_response_ready),
  .i_read_data      (o_read_data),
  .i_error          (o_error)
);

/* sim/csr_block_tb.sv */
`timescale 1ns/10ps

module csr_block_tb;
  import csr_pkg::*;

  localparam int          ADDRESS_WIDTH  = 8;
  localparam int          BUS_WIDTH      = 32;
  localparam int          WORD_WIDTH     = ADDRESS_WIDTH - 2;
  localparam int          TIMEOUT_CYCLES = 50;
  localparam logic [31:0] DEFAULT_DATA   = 32'hdead_beef;
  localparam logic [5:0]  CTRL_WORD      = 6'h00;
  localparam logic [5:0]  CONFIG_WORD    = 6'h01;
  localparam logic [5:0]  STATUS_WORD    = 6'h02;

  typedef struct {
    csr_access_e access;
    logic [5:0]  address;
    logic [31:0] write_data;
    logic [3:0]  strobe;
    logic [31:0] set_bits;
    logic [31:0] exp_read_data;
    logic        exp_error;
    logic [31:0] exp_ctrl;
    logic [31:0] exp_config;
  } row_t;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_request_valid;
  logic                  o_request_ready;
  logic [WORD_WIDTH-1:0] i_address;
  logic [BUS_WIDTH-1:0]  i_write_data;
  logic [3:0]            i_strobe;
  logic                  o_response_valid;
  logic                  i_response_ready;
  logic [BUS_WIDTH-1:0]  o_read_data;
  logic                  o_error;
  logic [BUS_WIDTH-1:0]  i_status_set;
  logic [BUS_WIDTH-1:0]  o_ctrl_value;
  logic [BUS_WIDTH-1:0]  o_config_value;

  row_t        table_q[$];
  logic [31:0] ctrl_model;
  logic [31:0] config_model;
  logic [31:0] status_model;
  logic [31:0] lcg_state;
  int          error_count;
  bit          timed_out;

  csr_block_top #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH),
    .INSERT_SLICER (1'b0)
  ) dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] strobe);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i+:8] = {8{strobe[i]}};
    end
    return mask;
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_row(input csr_access_e access, input logic [5:0] address,
                         input logic [31:0] data, input logic [3:0] strobe,
                         input logic [31:0] set_bits);
    row_t        row;
    logic [31:0] mask;
    mask = lane_mask(strobe);
    row.access = access;
    row.address = address;
    row.write_data = data;
    row.strobe = strobe;
    row.set_bits = set_bits;
    row.exp_error = 1'b0;
    status_model = status_model | set_bits; // pulse lands before the access.
    case (address)
      CTRL_WORD: begin
        row.exp_read_data = ctrl_model;
        if (access == CSR_WRITE) ctrl_model = (ctrl_model & ~mask) | (data & mask);
      end
      CONFIG_WORD: begin
        row.exp_read_data = config_model;
        if (access == CSR_WRITE) config_model = (config_model & ~mask) | (data & mask);
      end
      STATUS_WORD: begin
        row.exp_read_data = status_model;
        if (access == CSR_WRITE) status_model = status_model & ~(data & mask);
      end
      default: begin
        row.exp_read_data = DEFAULT_DATA;
        row.exp_error = 1'b1;
      end
    endcase
    row.exp_ctrl = ctrl_model;
    row.exp_config = config_model;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    ctrl_model = 32'h0;
    config_model = 32'h0000_00ff;
    status_model = 32'h0;
    add_row(CSR_READ,  CTRL_WORD,   32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  CONFIG_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  STATUS_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_WRITE, CTRL_WORD,   32'h1234_5678, 4'hf, 32'h0);
    add_row(CSR_READ,  CTRL_WORD,   32'h0,         4'h0, 32'h0);
    add_row(CSR_WRITE, CONFIG_WORD, 32'ha5a5_c3c3, 4'h5, 32'h0);
    add_row(CSR_READ,  CONFIG_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_WRITE, CONFIG_WORD, 32'h1111_2222, 4'ha, 32'h0);
    add_row(CSR_READ,  CONFIG_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  STATUS_WORD, 32'h0,         4'h0, 32'h8000_0011);
    add_row(CSR_WRITE, STATUS_WORD, 32'h0000_0001, 4'hf, 32'h0);
    add_row(CSR_READ,  STATUS_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_WRITE, STATUS_WORD, 32'hffff_ffff, 4'h8, 32'h0); // top byte only.
    add_row(CSR_READ,  STATUS_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  6'h30,       32'h0,         4'h0, 32'h0);
    add_row(CSR_WRITE, 6'h30,       32'hffff_ffff, 4'hf, 32'h0);
    add_row(CSR_READ,  CTRL_WORD,   32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  CONFIG_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  STATUS_WORD, 32'h0,         4'h0, 32'h0);
    add_row(CSR_READ,  6'h03,       32'h0,         4'h0, 32'h0); // hole inside the window.
    add_row(CSR_WRITE, CTRL_WORD,   32'hcafe_f00d, 4'hf, 32'h0);
    add_row(CSR_READ,  CTRL_WORD,   32'h0,         4'h0, 32'h0);
  endtask

  task automatic check_equal(input int row, input string what,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_request_ready();
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (!o_request_ready && !timed_out) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout at %0t: request ready never rose", $time);
        error_count++;
        timed_out = 1'b1;
      end else begin
        @(negedge i_clk);
      end
    end
  endtask

  task automatic wait_response_valid(output int latency);
    int cycles;
    cycles = 1;
    @(negedge i_clk);
    while (!o_response_valid && !timed_out) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout at %0t: no response after an accepted request", $time);
        error_count++;
        timed_out = 1'b1;
      end else begin
        @(negedge i_clk);
      end
    end
    latency = cycles;
  endtask

  task automatic pulse_status(input logic [31:0] set_bits);
    if (set_bits != 32'h0) begin
      @(posedge i_clk);
      i_status_set <= set_bits;
      @(posedge i_clk);
      i_status_set <= 32'h0;
    end
  endtask

  task automatic run_access(input int idx);
    row_t        row;
    int          latency;
    int          hold;
    logic [31:0] held_data;
    logic        held_error;
    row = table_q[idx];
    pulse_status(row.set_bits);
    @(posedge i_clk);
    i_request_valid <= 1'b1;
    i_address <= row.address;
    i_write_data <= row.write_data;
    i_strobe <= row.strobe;
    wait_request_ready();
    if (timed_out) return;
    @(posedge i_clk); // transfer edge.
    i_address <= CTRL_WORD; // competing write offered while the response is pending.
    i_write_data <= ~row.exp_ctrl;
    i_strobe <= 4'hf;
    wait_response_valid(latency);
    if (timed_out) return;
    check_equal(idx, "response latency", 32'(latency), 32'd1);
    if (row.access == CSR_READ) check_equal(idx, "read data", o_read_data, row.exp_read_data);
    check_equal(idx, "error", 32'(o_error), 32'(row.exp_error));
    held_data = o_read_data;
    held_error = o_error;
    hold = int'((next_random() >> 16) % 32'd4);
    repeat (hold) begin
      @(negedge i_clk);
      if (!o_response_valid || o_request_ready ||
          o_read_data !== held_data || o_error !== held_error) begin
        $display("CHECK FAILED at %0t: row %0d response not held under back-pressure",
                 $time, idx);
        error_count++;
      end
    end
    @(posedge i_clk);
    i_response_ready <= 1'b1;
    @(posedge i_clk); // acknowledge edge.
    i_response_ready <= 1'b0;
    i_request_valid <= 1'b0;
    @(negedge i_clk);
    check_equal(idx, "response valid after ack", 32'(o_response_valid), 32'd0);
    check_equal(idx, "ctrl value", o_ctrl_value, row.exp_ctrl);
    check_equal(idx, "config value", o_config_value, row.exp_config);
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_request_valid = 1'b0;
    i_address = '0;
    i_write_data = '0;
    i_strobe = '0;
    i_response_ready = 1'b0;
    i_status_set = '0;
    lcg_state = 32'h3c38ca74;
    error_count = 0;
    timed_out = 1'b0;
    build_table();
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    if (o_response_valid !== 1'b0 || o_error !== 1'b0 || o_request_ready !== 1'b1) begin
      $display("CHECK FAILED at %0t: host port not idle after reset", $time);
      error_count++;
    end
    for (int i = 0; i < table_q.size() && !timed_out; i++) begin
      run_access(i);
    end
    $display("rows: %0d, errors: %0d", table_q.size(), error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verilog/csr_adapter_common.sv */
`timescale 1ns/10ps

module csr_adapter_common #(
  parameter int                     ADDRESS_WIDTH     = 8,
  parameter int                     BUS_WIDTH         = 32,
  parameter int                     REGISTERS         = 1,
  parameter bit [ADDRESS_WIDTH-1:0] BASE_ADDRESS      = '0,
  parameter bit                     ERROR_STATUS      = 0,
  parameter bit [BUS_WIDTH-1:0]     DEFAULT_READ_DATA = '0,
  parameter bit                     INSERT_SLICER     = 0
)(
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  // internal bus
  input  logic                             i_bus_valid,
  input  csr_pkg::csr_access_e             i_bus_access,
  input  logic [ADDRESS_WIDTH-1:0]         i_bus_address,
  input  logic [BUS_WIDTH-1:0]             i_bus_write_data,
  input  logic [BUS_WIDTH/8-1:0]           i_bus_strobe,
  output logic                             o_bus_ready,
  output logic [BUS_WIDTH-1:0]             o_bus_read_data,
  output logic                             o_bus_error,
  // register broadcast
  output logic                             o_reg_valid,
  output csr_pkg::csr_access_e             o_reg_access,
  output logic [ADDRESS_WIDTH-1:0]         o_reg_address,
  output logic [BUS_WIDTH-1:0]             o_reg_write_data,
  output logic [BUS_WIDTH/8-1:0]           o_reg_strobe,
  input  logic [REGISTERS-1:0]             i_reg_active,
  input  logic [REGISTERS*BUS_WIDTH-1:0]   i_reg_read_data
);
  import csr_pkg::*;

  // bytes spanned by the register window.
  localparam int LOCAL_ADDRESS_WIDTH = $clog2(REGISTERS * (BUS_WIDTH / 8));
  localparam bit [ADDRESS_WIDTH-1:0] LOCAL_MASK =
    ADDRESS_WIDTH'((64'd1 << LOCAL_ADDRESS_WIDTH) - 64'd1);

  logic                     req_valid;
  csr_access_e              req_access;
  logic [ADDRESS_WIDTH-1:0] req_address;
  logic [BUS_WIDTH-1:0]     req_write_data;
  logic [BUS_WIDTH/8-1:0]   req_strobe;
  logic                     in_range;
  logic                     any_active;
  logic [BUS_WIDTH-1:0]     selected_data;

  ////////////////////////////////////////
  // request slicer
  ////////////////////////////////////////

  if (INSERT_SLICER) begin : g_slicer
    logic                     slice_valid;
    csr_access_e              slice_access;
    logic [ADDRESS_WIDTH-1:0] slice_address;
    logic [BUS_WIDTH-1:0]     slice_write_data;
    logic [BUS_WIDTH/8-1:0]   slice_strobe;

    // one cycle in the slice, then the transfer completes.
    always_ff @(posedge i_clk, negedge i_rst_n) begin
      if (!i_rst_n) begin
        slice_valid <= 1'b0;
      end else begin
        slice_valid <= i_bus_valid && !slice_valid;
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_bus_valid && !slice_valid) begin
        slice_access     <= i_bus_access;
        slice_address    <= i_bus_address;
        slice_write_data <= i_bus_write_data;
        slice_strobe     <= i_bus_strobe;
      end
    end

    assign req_valid      = slice_valid;
    assign req_access     = slice_access;
    assign req_address    = slice_address;
    assign req_write_data = slice_write_data;
    assign req_strobe     = slice_strobe;
    assign o_bus_ready    = slice_valid;
  end else begin : g_direct
    assign req_valid      = i_bus_valid;
    assign req_access     = i_bus_access;
    assign req_address    = i_bus_address;
    assign req_write_data = i_bus_write_data;
    assign req_strobe     = i_bus_strobe;
    assign o_bus_ready    = 1'b1; // registers never stall.
  end

  ////////////////////////////////////////
  // decode and broadcast
  ////////////////////////////////////////

  assign in_range = (req_address >> LOCAL_ADDRESS_WIDTH) == (BASE_ADDRESS >> LOCAL_ADDRESS_WIDTH);

  assign o_reg_valid      = req_valid && in_range;
  assign o_reg_access     = req_access;
  assign o_reg_address    = req_address & LOCAL_MASK; // offset within the block.
  assign o_reg_write_data = req_write_data;
  assign o_reg_strobe     = req_strobe;

  ////////////////////////////////////////
  // read data and error
  ////////////////////////////////////////

  always_comb begin
    selected_data = '0;
    for (int i = 0; i < REGISTERS; i++) begin
      if (i_reg_active[i]) begin
        selected_data = i_reg_read_data[i*BUS_WIDTH+:BUS_WIDTH];
      end
    end
  end

  assign any_active      = |i_reg_active;
  assign o_bus_read_data = any_active ? selected_data : DEFAULT_READ_DATA;
  assign o_bus_error     = ERROR_STATUS && req_valid && !any_active; // unmapped access.

endmodule

/* verilog/csr_block_top.sv */
`timescale 1ns/10ps

module csr_block_top #(
  parameter int                     ADDRESS_WIDTH = csr_pkg::CSR_ADDRESS_WIDTH,
  parameter int                     BUS_WIDTH     = csr_pkg::CSR_BUS_WIDTH,
  parameter bit [ADDRESS_WIDTH-1:0] BASE_ADDRESS  = '0,
  parameter bit                     INSERT_SLICER = 0
)(
  input  logic                                         i_clk,
  input  logic                                         i_rst_n,
  input  logic                                         i_request_valid,
  output logic                                         o_request_ready,
  input  logic [ADDRESS_WIDTH-$clog2(BUS_WIDTH/8)-1:0] i_address,
  input  logic [BUS_WIDTH-1:0]                         i_write_data,
  input  logic [BUS_WIDTH/8-1:0]                       i_strobe,
  output logic                                         o_response_valid,
  input  logic                                         i_response_ready,
  output logic [BUS_WIDTH-1:0]                         o_read_data,
  output logic                                         o_error,
  input  logic [BUS_WIDTH-1:0]                         i_status_set,
  output logic [BUS_WIDTH-1:0]                         o_ctrl_value,
  output logic [BUS_WIDTH-1:0]                         o_config_value
);
  import csr_pkg::*;

  localparam int                     REGISTERS     = 3;
  localparam bit [ADDRESS_WIDTH-1:0] CTRL_OFFSET   = ADDRESS_WIDTH'(8'h00);
  localparam bit [ADDRESS_WIDTH-1:0] CONFIG_OFFSET = ADDRESS_WIDTH'(8'h04);
  localparam bit [ADDRESS_WIDTH-1:0] STATUS_OFFSET = ADDRESS_WIDTH'(8'h08);

  logic                           bus_valid;
  csr_access_e                    bus_access;
  logic [ADDRESS_WIDTH-1:0]       bus_address;
  logic [BUS_WIDTH-1:0]           bus_write_data;
  logic [BUS_WIDTH/8-1:0]         bus_strobe;
  logic                           bus_ready;
  logic [BUS_WIDTH-1:0]           bus_read_data;
  logic                           bus_error;
  logic                           reg_valid;
  csr_access_e                    reg_access;
  logic [ADDRESS_WIDTH-1:0]       reg_address;
  logic [BUS_WIDTH-1:0]           reg_write_data;
  logic [BUS_WIDTH/8-1:0]         reg_strobe;
  logic [REGISTERS-1:0]           reg_active;
  logic [REGISTERS*BUS_WIDTH-1:0] reg_read_data;

  csr_bus_adapter #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH)
  ) u_bus_adapter (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_request_valid  (i_request_valid),
    .o_request_ready  (o_request_ready),
    .i_address        (i_address),
    .i_write_data     (i_write_data),
    .i_strobe         (i_strobe),
    .o_response_valid (o_response_valid),
    .i_response_ready (i_response_ready),
    .o_read_data      (o_read_data),
    .o_error          (o_error),
    .o_bus_valid      (bus_valid),
    .o_bus_access     (bus_access),
    .o_bus_address    (bus_address),
    .o_bus_write_data (bus_write_data),
    .o_bus_strobe     (bus_strobe),
    .i_bus_ready      (bus_ready),
    .i_bus_read_data  (bus_read_data),
    .i_bus_error      (bus_error)
  );

  csr_adapter_common #(
    .ADDRESS_WIDTH     (ADDRESS_WIDTH),
    .BUS_WIDTH         (BUS_WIDTH),
    .REGISTERS         (REGISTERS),
    .BASE_ADDRESS      (BASE_ADDRESS),
    .ERROR_STATUS      (1'b1),
    .DEFAULT_READ_DATA (BUS_WIDTH'(32'hdead_beef)),
    .INSERT_SLICER     (INSERT_SLICER)
  ) u_adapter_common (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_bus_valid      (bus_valid),
    .i_bus_access     (bus_access),
    .i_bus_address    (bus_address),
    .i_bus_write_data (bus_write_data),
    .i_bus_strobe     (bus_strobe),
    .o_bus_ready      (bus_ready),
    .o_bus_read_data  (bus_read_data),
    .o_bus_error      (bus_error),
    .o_reg_valid      (reg_valid),
    .o_reg_access     (reg_access),
    .o_reg_address    (reg_address),
    .o_reg_write_data (reg_write_data),
    .o_reg_strobe     (reg_strobe),
    .i_reg_active     (reg_active),
    .i_reg_read_data  (reg_read_data)
  );

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  csr_rw_register #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH),
    .OFFSET        (CTRL_OFFSET),
    .INITIAL_VALUE ('0)
  ) u_ctrl_reg (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (reg_valid),
    .i_access     (reg_access),
    .i_address    (reg_address),
    .i_write_data (reg_write_data),
    .i_strobe     (reg_strobe),
    .o_active     (reg_active[0]),
    .o_read_data  (reg_read_data[0*BUS_WIDTH+:BUS_WIDTH]),
    .o_value      (o_ctrl_value)
  );

  csr_rw_register #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH),
    .OFFSET        (CONFIG_OFFSET),
    .INITIAL_VALUE (BUS_WIDTH'(32'h0000_00ff))
  ) u_config_reg (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (reg_valid),
    .i_access     (reg_access),
    .i_address    (reg_address),
    .i_write_data (reg_write_data),
    .i_strobe     (reg_strobe),
    .o_active     (reg_active[1]),
    .o_read_data  (reg_read_data[1*BUS_WIDTH+:BUS_WIDTH]),
    .o_value      (o_config_value)
  );

  csr_status_register #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH),
    .OFFSET        (STATUS_OFFSET)
  ) u_status_reg (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (reg_valid),
    .i_access     (reg_access),
    .i_address    (reg_address),
    .i_write_data (reg_write_data),
    .i_strobe     (reg_strobe),
    .i_set        (i_status_set),
    .o_active     (reg_active[2]),
    .o_read_data  (reg_read_data[2*BUS_WIDTH+:BUS_WIDTH])
  );

endmodule

/* verilog/csr_bus_adapter.sv */
`timescale 1ns/10ps

module csr_bus_adapter #(
  parameter int ADDRESS_WIDTH = 8,
  parameter int BUS_WIDTH     = 32
)(
  input  logic                                           i_clk,
  input  logic                                           i_rst_n,
  // host request
  input  logic                                           i_request_valid,
  output logic                                           o_request_ready,
  input  logic [ADDRESS_WIDTH-$clog2(BUS_WIDTH/8)-1:0]   i_address,
  input  logic [BUS_WIDTH-1:0]                           i_write_data,
  input  logic [BUS_WIDTH/8-1:0]                         i_strobe,
  // host response
  output logic                                           o_response_valid,
  input  logic                                           i_response_ready,
  output logic [BUS_WIDTH-1:0]                           o_read_data,
  output logic                                           o_error,
  // internal bus
  output logic                                           o_bus_valid,
  output csr_pkg::csr_access_e                           o_bus_access,
  output logic [ADDRESS_WIDTH-1:0]                       o_bus_address,
  output logic [BUS_WIDTH-1:0]                           o_bus_write_data,
  output logic [BUS_WIDTH/8-1:0]                         o_bus_strobe,
  input  logic                                           i_bus_ready,
  input  logic [BUS_WIDTH-1:0]                           i_bus_read_data,
  input  logic                                           i_bus_error
);
  import csr_pkg::*;

  localparam int ADDRESS_LSB = $clog2(BUS_WIDTH / 8);

  logic                 response_valid;
  logic [BUS_WIDTH-1:0] read_data;
  logic                 error;
  logic                 bus_transfer;
  logic                 response_ack;

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  assign o_request_ready  = i_bus_ready && !response_valid; // one access in flight.
  assign o_bus_valid      = i_request_valid && !response_valid;
  assign o_bus_access     = (i_strobe != '0) ? CSR_WRITE : CSR_READ;
  assign o_bus_address    = {i_address, {ADDRESS_LSB{1'b0}}}; // word to byte address.
  assign o_bus_write_data = i_write_data;
  assign o_bus_strobe     = i_strobe;

  assign bus_transfer = o_bus_valid && i_bus_ready;
  assign response_ack = response_valid && i_response_ready;

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      response_valid <= 1'b0;
    end else if (response_ack) begin
      response_valid <= 1'b0;
    end else if (bus_transfer) begin
      response_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (bus_transfer) begin
      read_data <= i_bus_read_data; // held until acknowledge.
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      error <= 1'b0;
    end else if (bus_transfer) begin
      error <= i_bus_error;
    end
  end

  assign o_response_valid = response_valid;
  assign o_read_data      = read_data;
  assign o_error          = error;

endmodule

/* verilog/csr_pkg.sv */
package csr_pkg;

  ////////////////////////////////////////
  // access opcodes
  ////////////////////////////////////////

  // a request with any strobe bit set is a write.
  typedef enum logic {
    CSR_READ  = 1'b0,
    CSR_WRITE = 1'b1
  } csr_access_e;

  ////////////////////////////////////////
  // default widths
  ////////////////////////////////////////

  localparam int CSR_BUS_WIDTH     = 32; // data bits.
  localparam int CSR_ADDRESS_WIDTH = 8;  // byte address bits.

endpackage

/* verilog/csr_rw_register.sv */
`timescale 1ns/10ps

module csr_rw_register #(
  parameter int                     ADDRESS_WIDTH = 8,
  parameter int                     BUS_WIDTH     = 32,
  parameter bit [ADDRESS_WIDTH-1:0] OFFSET        = '0,
  parameter bit [BUS_WIDTH-1:0]     INITIAL_VALUE = '0
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  input  csr_pkg::csr_access_e     i_access,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  logic [BUS_WIDTH-1:0]     i_write_data,
  input  logic [BUS_WIDTH/8-1:0]   i_strobe,
  output logic                     o_active,
  output logic [BUS_WIDTH-1:0]     o_read_data,
  output logic [BUS_WIDTH-1:0]     o_value
);
  import csr_pkg::*;

  localparam int BYTE_WIDTH = BUS_WIDTH / 8;

  logic [BUS_WIDTH-1:0] value;
  logic                 write_hit;

  assign o_active  = i_valid && (i_address == OFFSET);
  assign write_hit = o_active && (i_access == CSR_WRITE);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      value <= INITIAL_VALUE;
    end else if (write_hit) begin
      for (int i = 0; i < BYTE_WIDTH; i++) begin
        if (i_strobe[i]) begin
          value[8*i+:8] <= i_write_data[8*i+:8]; // strobed lanes only.
        end
      end
    end
  end

  assign o_read_data = value;
  assign o_value     = value;

endmodule

/* verilog/csr_status_register.sv */
`timescale 1ns/10ps

module csr_status_register #(
  parameter int                     ADDRESS_WIDTH = 8,
  parameter int                     BUS_WIDTH     = 32,
  parameter bit [ADDRESS_WIDTH-1:0] OFFSET        = '0
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  input  csr_pkg::csr_access_e     i_access,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  logic [BUS_WIDTH-1:0]     i_write_data,
  input  logic [BUS_WIDTH/8-1:0]   i_strobe,
  input  logic [BUS_WIDTH-1:0]     i_set,
  output logic                     o_active,
  output logic [BUS_WIDTH-1:0]     o_read_data
);
  import csr_pkg::*;

  localparam int BYTE_WIDTH = BUS_WIDTH / 8;

  logic [BUS_WIDTH-1:0] bits;
  logic [BUS_WIDTH-1:0] clear_mask;

  assign o_active = i_valid && (i_address == OFFSET);

  always_comb begin
    clear_mask = '0;
    if (o_active && (i_access == CSR_WRITE)) begin
      for (int i = 0; i < BYTE_WIDTH; i++) begin
        if (i_strobe[i]) begin
          clear_mask[8*i+:8] = i_write_data[8*i+:8]; // write one to clear.
        end
      end
    end
  end

  // a set pulse beats a clear in the same cycle.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      bits <= '0;
    end else begin
      bits <= (bits & ~clear_mask) | i_set;
    end
  end

  assign o_read_data = bits;

endmodule
